// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_fsmc_regs
FILELIST  = fsmc_regs.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the testbench printed its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== fsmc_regs.f ====
logic/bus_types_pkg.sv
logic/reg_map_pkg.sv
logic/bus_sync.sv
logic/bus_ctrl.sv
logic/reg_bank.sv
logic/fsmc_regs_top.sv
test/tb_clock.sv
test/tb_fsmc_regs.sv

// ==== logic/bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl
    import bus_types_pkg::*;
    import reg_map_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  bus_sample_t sample,
    input  reg_data_t   rdata,
    output reg_req_t    req,
    output bus_word_t   ad_out,
    output logic        ad_oe
);

    ctrl_state_t state;
    // address from the last NADV phase
    bus_word_t   addr_q;
    // one cycle at read entry
    logic        rd_pulse;
    logic        wr_fire;
    logic        go_write;
    logic        go_read;

    // commit on NWE rise, unless a new address phase cut in
    assign wr_fire  = (state == ST_WRITE) && sample.nadv && sample.nwe_rise;
    // data phase only once NADV is back high
    assign go_write = (state == ST_ADDR) && sample.nadv && !sample.nwe;
    assign go_read  = (state == ST_ADDR) && sample.nadv && sample.nwe && sample.noe_fall;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            addr_q   <= '0;
            ad_out   <= '0;
            ad_oe    <= 1'b0;
            rd_pulse <= 1'b0;
        end else begin
            rd_pulse <= 1'b0;
            // address capture on the NADV rising edge
            if (state == ST_ADDR && sample.nadv_rise) begin
                addr_q <= sample.ad;
            end
            case (state)
                ST_IDLE: begin
                    if (!sample.nadv) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (go_write) begin
                        state <= ST_WRITE;
                    end else if (go_read) begin
                        state    <= ST_READ;
                        rd_pulse <= 1'b1;
                        // snapshot, held for the whole NOE low time
                        ad_out   <= bus_word_t'(rdata);
                        ad_oe    <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    // new address phase aborts, nothing written
                    if (!sample.nadv) begin
                        state <= ST_ADDR;
                    end else if (sample.nwe_rise) begin
                        state <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (!sample.nadv) begin
                        state <= ST_ADDR;
                        ad_oe <= 1'b0;
                    end else if (sample.noe_rise) begin
                        state <= ST_IDLE;
                        ad_oe <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        req.wr_en = wr_fire;
        req.rd_en = rd_pulse;
        req.addr  = addr_q;
        // data rides on the low AD bits during the write phase
        req.wdata = sample.ad[15:0];
    end

    // never drive the bus while the MCU is writing
    a_no_oe_in_write: assert property (@(posedge clk) disable iff (rst)
        ad_oe |-> sample.nwe);

    // write and read requests are exclusive
    a_req_onehot: assert property (@(posedge clk) disable iff (rst)
        !(req.wr_en && req.rd_en));

endmodule

`default_nettype wire

// ==== logic/bus_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_sync
    import bus_types_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        nadv,
    input  logic        nwe,
    input  logic        noe,
    input  bus_word_t   ad_in,
    output bus_sample_t sample
);

    // strobe chains where bit 0 sees the pin first
    logic [SYNC_STAGES-1:0] nadv_q;
    logic [SYNC_STAGES-1:0] nwe_q;
    logic [SYNC_STAGES-1:0] noe_q;
    // AD chain where entry 0 sees the pin first
    bus_word_t ad_q [SYNC_STAGES];

    // extra stage holding the previous level for edge compare
    logic nadv_d;
    logic nwe_d;
    logic noe_d;

    // registered edge pulses
    logic nadv_rise;
    logic nwe_rise;
    logic noe_fall;
    logic noe_rise;

    always_ff @(posedge clk) begin
        if (rst) begin
            // strobes idle high so no false edge leaves reset
            nadv_q    <= '1;
            nwe_q     <= '1;
            noe_q     <= '1;
            nadv_d    <= 1'b1;
            nwe_d     <= 1'b1;
            noe_d     <= 1'b1;
            nadv_rise <= 1'b0;
            nwe_rise  <= 1'b0;
            noe_fall  <= 1'b0;
            noe_rise  <= 1'b0;
        end else begin
            nadv_q <= {nadv_q[SYNC_STAGES-2:0], nadv};
            nwe_q  <= {nwe_q[SYNC_STAGES-2:0], nwe};
            noe_q  <= {noe_q[SYNC_STAGES-2:0], noe};
            nadv_d <= nadv_q[SYNC_STAGES-1];
            nwe_d  <= nwe_q[SYNC_STAGES-1];
            noe_d  <= noe_q[SYNC_STAGES-1];
            // pulse lands with the delayed level S+1 clocks after the pin
            nadv_rise <= nadv_q[SYNC_STAGES-1] & ~nadv_d;
            nwe_rise  <= nwe_q[SYNC_STAGES-1] & ~nwe_d;
            noe_fall  <= ~noe_q[SYNC_STAGES-1] & noe_d;
            noe_rise  <= noe_q[SYNC_STAGES-1] & ~noe_d;
        end
    end

    always_ff @(posedge clk) begin
        ad_q[0] <= ad_in;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            ad_q[i] <= ad_q[i-1];
        end
    end

    always_comb begin
        sample.ad        = ad_q[SYNC_STAGES-1];
        // delayed copies serve as levels aligned with the pulses
        sample.nadv      = nadv_d;
        sample.nwe       = nwe_d;
        sample.noe       = noe_d;
        sample.nadv_rise = nadv_rise;
        sample.nwe_rise  = nwe_rise;
        sample.noe_fall  = noe_fall;
        sample.noe_rise  = noe_rise;
    end

endmodule

`default_nettype wire

// ==== logic/bus_types_pkg.sv ====
`default_nettype none

// MCU side of the multiplexed address/data bus
package bus_types_pkg;

    // raw AD bus, address and data share these pins
    typedef logic [17:0] bus_word_t;

    // one synchronized view of the bus pins
    // levels and pulses line up on the same cycle
    typedef struct packed {
        bus_word_t ad;
        // strobe levels, active low
        logic      nadv;
        logic      nwe;
        logic      noe;
        // one-cycle edge pulses
        logic      nadv_rise;
        logic      nwe_rise;
        logic      noe_fall;
        logic      noe_rise;
    } bus_sample_t;

    // access FSM of the bus controller
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ADDR  = 2'd1,
        ST_WRITE = 2'd2,
        ST_READ  = 2'd3
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/fsmc_regs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fsmc_regs_top
    import bus_types_pkg::*;
    import reg_map_pkg::*;
#(
    // power of two, 2 up to 256
    parameter int REG_COUNT   = 8,
    // 2 or 3
    parameter int SYNC_STAGES = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      nadv,
    input  logic      nwe,
    input  logic      noe,
    input  bus_word_t ad_in,
    output bus_word_t ad_out,
    output logic      ad_oe
);

    bus_sample_t sample;
    reg_req_t    req;
    reg_data_t   rdata;

    // pins into the clk domain
    bus_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_sync (
        .clk   (clk),
        .rst   (rst),
        .nadv  (nadv),
        .nwe   (nwe),
        .noe   (noe),
        .ad_in (ad_in),
        .sample(sample)
    );

    bus_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .sample(sample),
        .rdata (rdata),
        .req   (req),
        .ad_out(ad_out),
        .ad_oe (ad_oe)
    );

    reg_bank #(
        .REG_COUNT(REG_COUNT)
    ) u_bank (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .rdata(rdata)
    );

endmodule

`default_nettype wire

// ==== logic/reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_bank
    import reg_map_pkg::*;
#(
    parameter int REG_COUNT = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  reg_req_t  req,
    output reg_data_t rdata
);

    localparam int IDX_W = $clog2(REG_COUNT);

    // index 0 is the identity word, not stored
    reg_data_t [REG_COUNT-1:1] regs;

    reg_region_t      region;
    logic [IDX_W-1:0] idx;
    logic             hit;
    logic             wr_ok;

    assign region = req.addr[17:16];
    assign idx    = req.addr[IDX_W-1:0];
    // bits between the index and the region must be clear
    assign hit    = (region == REGION_REGS) && (req.addr[15:IDX_W] == '0);
    // identity word is read-only
    assign wr_ok  = req.wr_en && hit && (idx != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '0;
        end else if (wr_ok) begin
            regs[idx] <= req.wdata;
        end
    end

    // read path, combinational from the latched address
    always_comb begin
        if (!hit) begin
            rdata = '0;
        end else if (idx == '0) begin
            rdata = REG_ID_VALUE;
        end else begin
            rdata = regs[idx];
        end
    end

    // a write aimed at index 0 leaves the whole bank untouched
    a_id_read_only: assert property (@(posedge clk) disable iff (rst)
        (req.wr_en && idx == '0) |=> $stable(regs));

endmodule

`default_nettype wire

// ==== logic/reg_map_pkg.sv ====
`default_nettype none

// register map seen through the bus
package reg_map_pkg;

    import bus_types_pkg::*;

    // one register word, low 16 bits of AD
    typedef logic [15:0] reg_data_t;

    // region code, address bits 17:16
    typedef logic [1:0] reg_region_t;

    // region 1 holds the register bank
    localparam reg_region_t REGION_REGS = 2'd1;

    // read-only identity at index 0
    localparam reg_data_t REG_ID_VALUE = 16'hA5C3;

    // request from the controller into the bank
    typedef struct packed {
        logic      wr_en;
        logic      rd_en;
        // full latched address, region and index both live here
        bus_word_t addr;
        reg_data_t wdata;
    } reg_req_t;

endpackage

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

// free-running testbench clock
module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        // start low so the first edge is a rising one
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== test/tb_fsmc_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fsmc_regs
    import bus_types_pkg::*;
    import reg_map_pkg::*;
();

    localparam int REG_COUNT = 8;
    localparam int IDX_W = $clog2(REG_COUNT);
    // clocks per bus phase, well above SYNC_STAGES+2
    localparam int PHASE_CLKS = 8;
    // expected identity word and bank region
    localparam reg_data_t ID_WORD = 16'hA5C3;
    localparam logic [1:0] BANK_REGION = 2'd1;

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } op_t;

    // one table entry
    typedef struct packed {
        op_t       op;
        // data drawn from $random when set
        logic      rnd;
        bus_word_t addr;
        reg_data_t data;
    } step_t;

    logic      clk;
    logic      rst;
    logic      nadv;
    logic      nwe;
    logic      noe;
    bus_word_t mcu_ad;
    bus_word_t ad_in;
    bus_word_t ad_out;
    logic      ad_oe;

    step_t     steps[$];
    // predicted bank contents, index 0 unused
    reg_data_t shadow [REG_COUNT];
    integer    seed;
    int        cycles = 0;

    tb_clock #(.PERIOD_NS(8)) u_clk (.clk(clk));

    // shared AD pins, slave wins while it drives
    assign ad_in = ad_oe ? ad_out : mcu_ad;

    fsmc_regs_top uut (
        .clk   (clk),
        .rst   (rst),
        .nadv  (nadv),
        .nwe   (nwe),
        .noe   (noe),
        .ad_in (ad_in),
        .ad_out(ad_out),
        .ad_oe (ad_oe)
    );

    // run limit from table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= steps.size() * 40 + 100) begin
            $display("run did not finish within %0d clock cycles", cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_data(string name, reg_data_t got, reg_data_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_oe(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "enable mismatch");
        end
    endtask

    // region 1 and nothing set between index and region
    function automatic logic is_hit(bus_word_t addr);
        return (addr[17:16] == BANK_REGION) && (addr[15:IDX_W] == '0);
    endfunction

    function automatic reg_data_t predict_read(bus_word_t addr);
        int idx;
        idx = int'(addr[IDX_W-1:0]);
        if (!is_hit(addr)) return '0;
        if (idx == 0) return ID_WORD;
        return shadow[idx];
    endfunction

    function automatic void note_write(bus_word_t addr, reg_data_t data);
        int idx;
        idx = int'(addr[IDX_W-1:0]);
        // identity and misses keep the bank as is
        if (is_hit(addr) && idx != 0) shadow[idx] = data;
    endfunction

    function automatic void add_step(op_t op, logic rnd, bus_word_t addr, reg_data_t data);
        step_t s;
        s.op   = op;
        s.rnd  = rnd;
        s.addr = addr;
        s.data = data;
        steps.push_back(s);
    endfunction

    task automatic build_table();
        // identity right after reset
        add_step(OP_READ, 1'b0, 18'h10000, '0);
        // every writable index, write then read back
        for (int i = 1; i < REG_COUNT; i++) begin
            add_step(OP_WRITE, 1'b1, 18'h10000 | bus_word_t'(i), '0);
            add_step(OP_READ, 1'b0, 18'h10000 | bus_word_t'(i), '0);
        end
        // overwrite two indices
        add_step(OP_WRITE, 1'b1, 18'h10003, '0);
        add_step(OP_READ, 1'b0, 18'h10003, '0);
        add_step(OP_WRITE, 1'b1, 18'h10006, '0);
        add_step(OP_READ, 1'b0, 18'h10006, '0);
        // identity is read-only
        add_step(OP_WRITE, 1'b0, 18'h10000, 16'h1234);
        add_step(OP_READ, 1'b0, 18'h10000, '0);
        // misses: regions 0, 2, 3 and bits above the index
        add_step(OP_WRITE, 1'b0, 18'h00002, 16'hDEAD);
        add_step(OP_WRITE, 1'b0, 18'h20004, 16'hBEEF);
        add_step(OP_WRITE, 1'b0, 18'h30005, 16'h5A5A);
        add_step(OP_WRITE, 1'b0, 18'h10014, 16'h0F0F);
        add_step(OP_WRITE, 1'b0, 18'h10009, 16'hC3C3);
        add_step(OP_READ, 1'b0, 18'h00002, '0);
        add_step(OP_READ, 1'b0, 18'h20004, '0);
        add_step(OP_READ, 1'b0, 18'h30005, '0);
        add_step(OP_READ, 1'b0, 18'h10014, '0);
        add_step(OP_READ, 1'b0, 18'h10009, '0);
        // whole bank still as predicted
        for (int i = 0; i < REG_COUNT; i++) begin
            add_step(OP_READ, 1'b0, 18'h10000 | bus_word_t'(i), '0);
        end
    endtask

    // NADV low with the address, then back high
    task automatic address_phase(bus_word_t addr);
        mcu_ad = addr;
        nadv   = 1'b0;
        repeat (PHASE_CLKS) begin
            @(negedge clk);
            check_oe("ad_oe", ad_oe, 1'b0);
        end
        nadv = 1'b1;
        repeat (PHASE_CLKS) begin
            @(negedge clk);
            check_oe("ad_oe", ad_oe, 1'b0);
        end
    endtask

    task automatic bus_write(bus_word_t addr, reg_data_t data);
        address_phase(addr);
        mcu_ad = {2'b00, data};
        nwe    = 1'b0;
        // slave must stay off the bus the whole time
        repeat (PHASE_CLKS) begin
            @(negedge clk);
            check_oe("ad_oe", ad_oe, 1'b0);
        end
        nwe = 1'b1;
        repeat (PHASE_CLKS) begin
            @(negedge clk);
            check_oe("ad_oe", ad_oe, 1'b0);
        end
    endtask

    task automatic bus_read(bus_word_t addr, output bus_word_t got);
        address_phase(addr);
        noe = 1'b0;
        repeat (PHASE_CLKS) @(negedge clk);
        // sample just before NOE goes back high
        if (ad_oe !== 1'b1) begin
            $display("read at address %h: the slave never enabled its output", addr);
            $display("TEST RESULT: FAIL");
            $fatal(1, "no output enable");
        end
        got = ad_out;
        noe = 1'b1;
        repeat (PHASE_CLKS) @(negedge clk);
        check_oe("ad_oe", ad_oe, 1'b0);
    endtask

    initial begin
        step_t     st;
        bus_word_t got;
        reg_data_t wdata;
        seed   = 32'h8d17;
        rst    = 1'b1;
        nadv   = 1'b1;
        nwe    = 1'b1;
        noe    = 1'b1;
        mcu_ad = '0;
        foreach (shadow[i]) shadow[i] = '0;
        build_table();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // idle bus, output stays off
        repeat (6) begin
            @(negedge clk);
            check_oe("ad_oe", ad_oe, 1'b0);
        end
        foreach (steps[i]) begin
            st = steps[i];
            if (st.op == OP_WRITE) begin
                wdata = st.rnd ? reg_data_t'($random(seed)) : st.data;
                bus_write(st.addr, wdata);
                note_write(st.addr, wdata);
            end else begin
                bus_read(st.addr, got);
                check_data("ad_out", got[15:0], predict_read(st.addr));
                // upper AD bits are zero-extended
                check_data("ad_out[17:16]", reg_data_t'(got[17:16]), '0);
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
